//--- hdl/conv_pkg.sv
`default_nettype none

package conv_pkg;

    // datapath widths. Pixels, weights and sums are signed.
    localparam int PIX_W  = 8;
    localparam int WGT_W  = 8;
    localparam int SUM_W  = 20;

    // the pixel buffer holds 256 pixels and the row table 16 rows.
    localparam int ADDR_W = 8;
    localparam int ROW_W  = 4;
    localparam int WIN_W  = 8;

    // lane index width on the weight load port and in the output result.
    localparam int LANE_W = 2;

    typedef logic signed [PIX_W-1:0] pixel_t;
    typedef logic signed [WGT_W-1:0] weight_t;
    typedef logic signed [SUM_W-1:0] sum_t;
    typedef logic [ADDR_W-1:0]       pix_addr_t;
    typedef logic [ROW_W-1:0]        row_idx_t;
    typedef logic [WIN_W-1:0]        win_idx_t;
    typedef logic [LANE_W-1:0]       lane_idx_t;

    // identifies one window. last_of_job marks the final window of a job.
    typedef struct packed {
        row_idx_t row;
        win_idx_t window;
        logic     last_of_job;
    } win_tag_t;

    // one row of the input map, end_addr is exclusive.
    typedef struct packed {
        pix_addr_t start_addr;
        pix_addr_t end_addr;
    } row_entry_t;

    typedef struct packed {
        logic      valid;
        pix_addr_t addr;
        logic      first;
        logic      last;
        win_tag_t  tag;
    } pix_req_t;

    typedef struct packed {
        logic     valid;
        pixel_t   pixel;
        logic     first;
        logic     last;
        win_tag_t tag;
    } pix_beat_t;

    typedef struct packed {
        logic     valid;
        sum_t     sum;
        win_tag_t tag;
    } lane_result_t;

    typedef struct packed {
        lane_idx_t lane;
        sum_t      sum;
        win_tag_t  tag;
    } out_result_t;

    typedef enum logic [1:0] {
        IDLE,
        FETCH,
        HEAD,
        WINDOW
    } gen_state_e;

endpackage

`default_nettype wire

//--- hdl/ifmap_addr_gen.sv
`timescale 1ns/100ps
`default_nettype none

module ifmap_addr_gen #(
    parameter int FILTER_SIZE = 4,
    parameter int STRIDE_W    = 3,
    localparam int TAP_W      = (FILTER_SIZE > 1) ? $clog2(FILTER_SIZE) : 1
) (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        start,
    input  wire                        row_wr,
    input  wire conv_pkg::row_idx_t    row_waddr,
    input  wire conv_pkg::row_entry_t  row_wdata,
    input  wire conv_pkg::row_idx_t    num_rows,
    input  wire [STRIDE_W-1:0]         stride,
    output conv_pkg::pix_req_t         req,
    output logic                       busy
);
    import conv_pkg::*;

    localparam logic [ADDR_W:0] FS_EXT = (ADDR_W + 1)'(FILTER_SIZE);

    // after the last request the pipeline still needs buffer, lane and serializer cycles.
    localparam int DRAIN_W = $clog2(FILTER_SIZE + 3);
    localparam logic [DRAIN_W-1:0] DRAIN_FULL  = DRAIN_W'(FILTER_SIZE + 2);
    localparam logic [DRAIN_W-1:0] DRAIN_EMPTY = DRAIN_W'(3);

    gen_state_e           state;
    row_entry_t           row_table [2**ROW_W];
    logic [2**ROW_W-1:0]  row_has_win;
    row_entry_t           entry_q;
    pix_addr_t            head;
    pix_addr_t            end_q;
    row_idx_t             row_ptr;
    logic [TAP_W-1:0]     tap;
    win_idx_t             win;
    logic [DRAIN_W-1:0]   drain;
    logic                 last_tap;
    logic                 fits_next;
    logic                 more_rows;

    assign last_tap  = (tap == TAP_W'(FILTER_SIZE - 1));
    assign fits_next = ({1'b0, head} + (ADDR_W + 1)'(stride) + FS_EXT) <= {1'b0, end_q};
    assign busy      = (state != IDLE) || (drain != '0);

    // looks ahead for any later row of this job that still holds a full window.
    always_comb begin
        more_rows = 1'b0;
        for (int i = 0; i < 2**ROW_W; i++) begin
            if (row_has_win[i] && (row_idx_t'(i) > row_ptr) && (row_idx_t'(i) < num_rows)) begin
                more_rows = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= IDLE;
            row_ptr <= '0;
            tap     <= '0;
            win     <= '0;
            drain   <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (drain != '0) begin
                        drain <= drain - 1'b1;
                    end else if (start) begin
                        row_ptr <= '0;
                        state   <= FETCH;
                    end
                end
                FETCH: begin
                    // only reached with row_ptr at num_rows when no row had a window.
                    if (row_ptr == num_rows) begin
                        drain <= DRAIN_EMPTY;
                        state <= IDLE;
                    end else begin
                        state <= HEAD;
                    end
                end
                HEAD: begin
                    tap <= '0;
                    win <= '0;
                    if (row_has_win[row_ptr]) begin
                        state <= WINDOW;
                    end else begin
                        row_ptr <= row_ptr + 1'b1;
                        state   <= FETCH;
                    end
                end
                WINDOW: begin
                    if (!last_tap) begin
                        tap <= tap + 1'b1;
                    end else begin
                        tap <= '0;
                        if (fits_next) begin
                            win <= win + 1'b1;
                        end else if (more_rows) begin
                            row_ptr <= row_ptr + 1'b1;
                            state   <= FETCH;
                        end else begin
                            drain <= DRAIN_FULL;
                            state <= IDLE;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (row_wr) begin
            row_table[row_waddr]   <= row_wdata;
            row_has_win[row_waddr] <=
                ((ADDR_W + 1)'(row_wdata.start_addr) + FS_EXT) <= {1'b0, row_wdata.end_addr};
        end
        if (state == FETCH) begin
            entry_q <= row_table[row_ptr];
        end
        if (state == HEAD) begin
            head  <= entry_q.start_addr;
            end_q <= entry_q.end_addr;
        end else if (state == WINDOW && last_tap && fits_next) begin
            head <= head + pix_addr_t'(stride);
        end
    end

    always_comb begin
        req = '0;
        if (state == WINDOW) begin
            req.valid           = 1'b1;
            req.addr            = head + pix_addr_t'(tap);
            req.first           = (tap == '0);
            req.last            = last_tap;
            req.tag.row         = row_ptr;
            req.tag.window      = win;
            req.tag.last_of_job = last_tap && !fits_next && !more_rows;
        end else if (state == FETCH && row_ptr == num_rows) begin
            // empty job, a tag-only request still carries the end marker.
            req.tag.row         = row_ptr;
            req.tag.last_of_job = 1'b1;
        end
    end

    a_stride_nonzero: assert property (@(posedge clk) disable iff (rst)
        busy |-> (stride != '0));

endmodule

`default_nettype wire

//--- hdl/ifmap_buffer.sv
`timescale 1ns/100ps
`default_nettype none

module ifmap_buffer (
    input  wire                      clk,
    input  wire                      pix_wr,
    input  wire conv_pkg::pix_addr_t pix_waddr,
    input  wire conv_pkg::pixel_t    pix_wdata,
    input  wire conv_pkg::pix_req_t  req,
    output conv_pkg::pix_beat_t      beat
);
    import conv_pkg::*;

    pixel_t mem [2**ADDR_W];

    // host writes land here between jobs.
    always_ff @(posedge clk) begin
        if (pix_wr) begin
            mem[pix_waddr] <= pix_wdata;
        end
    end

    // the read takes one cycle, so the markers are delayed by the same register stage.
    always_ff @(posedge clk) begin
        beat.pixel <= mem[req.addr];
        beat.valid <= req.valid;
        beat.first <= req.first;
        beat.last  <= req.last;
        beat.tag   <= req.tag;
    end

endmodule

`default_nettype wire

//--- hdl/mac_lane.sv
`timescale 1ns/100ps
`default_nettype none

module mac_lane #(
    parameter int FILTER_SIZE = 4,
    parameter int LANE_ID     = 0,
    localparam int TAP_W      = (FILTER_SIZE > 1) ? $clog2(FILTER_SIZE) : 1
) (
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       wgt_wr,
    input  wire conv_pkg::lane_idx_t  wgt_lane,
    input  wire [TAP_W-1:0]           wgt_tap,
    input  wire conv_pkg::weight_t    wgt_data,
    input  wire conv_pkg::pix_beat_t  beat,
    output conv_pkg::lane_result_t    result
);
    import conv_pkg::*;

    weight_t           taps [FILTER_SIZE];
    logic [TAP_W-1:0]  tap_idx;
    logic [TAP_W-1:0]  cur_tap;
    sum_t              prod;
    sum_t              acc;
    sum_t              acc_next;
    logic              res_load;
    logic              res_valid;
    logic              res_end;
    sum_t              res_sum;
    win_tag_t          res_tag;

    // the first beat always uses tap 0, later beats follow the lane's own count.
    assign cur_tap  = beat.first ? '0 : tap_idx;
    assign prod     = sum_t'($signed(beat.pixel)) * sum_t'(taps[cur_tap]);
    assign acc_next = (beat.first ? sum_t'(0) : acc) + prod;

    // a tag-only end marker is passed on so the serializer can close an empty job.
    assign res_load = (beat.valid && beat.last) || (!beat.valid && beat.tag.last_of_job);

    always_ff @(posedge clk) begin
        if (wgt_wr && wgt_lane == lane_idx_t'(LANE_ID)) begin
            taps[wgt_tap] <= wgt_data;
        end
        if (beat.valid) begin
            acc <= acc_next;
        end
        if (res_load) begin
            res_sum <= acc_next;
            res_tag <= beat.tag;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            tap_idx   <= '0;
            res_valid <= 1'b0;
            res_end   <= 1'b0;
        end else begin
            if (beat.valid) begin
                tap_idx <= cur_tap + 1'b1;
            end
            res_valid <= res_load && beat.valid;
            res_end   <= res_load && beat.tag.last_of_job;
        end
    end

    always_comb begin
        result                 = '0;
        result.valid           = res_valid;
        result.sum             = res_sum;
        result.tag             = res_tag;
        result.tag.last_of_job = res_end;
    end

    a_window_len: assert property (@(posedge clk) disable iff (rst)
        (beat.valid && beat.first) |-> ##(FILTER_SIZE - 1) (beat.valid && beat.last));

endmodule

`default_nettype wire

//--- hdl/result_serializer.sv
`timescale 1ns/100ps
`default_nettype none

module result_serializer #(
    parameter int NUM_LANES   = 4,
    parameter int FILTER_SIZE = 4
) (
    input  wire                          clk,
    input  wire                          rst,
    input  wire conv_pkg::lane_result_t  results [NUM_LANES],
    output logic                         out_valid,
    output conv_pkg::out_result_t        out_result,
    output logic                         done
);
    import conv_pkg::*;

    sum_t                  sum_q [NUM_LANES];
    logic [LANE_W:0]       remaining;
    logic                  batch_last;
    logic                  capture;
    lane_idx_t             next_lane;
    logic [NUM_LANES-1:0]  lane_valids;

    // the drain only finishes before the next window if NUM_LANES fits in FILTER_SIZE.
    if (NUM_LANES > FILTER_SIZE || NUM_LANES > 2**LANE_W) begin : g_bad_lanes
        $error("result_serializer: NUM_LANES exceeds FILTER_SIZE or the lane index range.");
    end

    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            lane_valids[i] = results[i].valid;
        end
    end

    assign capture   = results[0].valid || results[0].tag.last_of_job;
    assign next_lane = out_result.lane + 1'b1;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid  <= 1'b0;
            done       <= 1'b0;
            remaining  <= '0;
            batch_last <= 1'b0;
        end else begin
            out_valid <= 1'b0;
            done      <= 1'b0;
            if (capture && results[0].valid) begin
                out_valid  <= 1'b1;
                remaining  <= (LANE_W + 1)'(NUM_LANES - 1);
                batch_last <= results[0].tag.last_of_job;
                done       <= (NUM_LANES == 1) && results[0].tag.last_of_job;
            end else if (capture) begin
                done <= 1'b1;   // empty job
            end else if (remaining != '0) begin
                out_valid <= 1'b1;
                remaining <= remaining - 1'b1;
                done      <= batch_last && (remaining == 1);
            end
        end
    end

    // lane 0 goes out straight from the capture, the others from the held sums.
    always_ff @(posedge clk) begin
        if (capture) begin
            for (int i = 0; i < NUM_LANES; i++) begin
                sum_q[i] <= results[i].sum;
            end
            out_result.lane <= '0;
            out_result.sum  <= results[0].sum;
            out_result.tag  <= results[0].tag;
        end else if (remaining != '0) begin
            out_result.lane <= next_lane;
            out_result.sum  <= sum_q[next_lane];
        end
    end

    a_lanes_aligned: assert property (@(posedge clk) disable iff (rst)
        (|lane_valids) |-> (&lane_valids));

    a_no_overlap: assert property (@(posedge clk) disable iff (rst)
        capture |-> (remaining == '0));

endmodule

`default_nettype wire

//--- hdl/conv_row_engine.sv
`timescale 1ns/100ps
`default_nettype none

module conv_row_engine #(
    parameter int FILTER_SIZE = 4,
    parameter int NUM_LANES   = 4,
    parameter int STRIDE_W    = 3,
    localparam int TAP_W      = (FILTER_SIZE > 1) ? $clog2(FILTER_SIZE) : 1
) (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        row_wr,
    input  wire conv_pkg::row_idx_t    row_waddr,
    input  wire conv_pkg::row_entry_t  row_wdata,
    input  wire                        pix_wr,
    input  wire conv_pkg::pix_addr_t   pix_waddr,
    input  wire conv_pkg::pixel_t      pix_wdata,
    input  wire                        wgt_wr,
    input  wire conv_pkg::lane_idx_t   wgt_lane,
    input  wire [TAP_W-1:0]            wgt_tap,
    input  wire conv_pkg::weight_t     wgt_data,
    input  wire                        start,
    input  wire conv_pkg::row_idx_t    num_rows,
    input  wire [STRIDE_W-1:0]         stride,
    output logic                       busy,
    output logic                       out_valid,
    output conv_pkg::out_result_t      out_result,
    output logic                       done
);
    import conv_pkg::*;

    wire pix_req_t     req;
    wire pix_beat_t    beat;
    wire lane_result_t lane_results [NUM_LANES];

    ifmap_addr_gen #(
        .FILTER_SIZE (FILTER_SIZE),
        .STRIDE_W    (STRIDE_W)
    ) gen_i (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .row_wr    (row_wr),
        .row_waddr (row_waddr),
        .row_wdata (row_wdata),
        .num_rows  (num_rows),
        .stride    (stride),
        .req       (req),
        .busy      (busy)
    );

    ifmap_buffer buf_i (
        .clk       (clk),
        .pix_wr    (pix_wr),
        .pix_waddr (pix_waddr),
        .pix_wdata (pix_wdata),
        .req       (req),
        .beat      (beat)
    );

    // every lane sees the same beat and computes one output channel.
    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        mac_lane #(
            .FILTER_SIZE (FILTER_SIZE),
            .LANE_ID     (i)
        ) lane_i (
            .clk      (clk),
            .rst      (rst),
            .wgt_wr   (wgt_wr),
            .wgt_lane (wgt_lane),
            .wgt_tap  (wgt_tap),
            .wgt_data (wgt_data),
            .beat     (beat),
            .result   (lane_results[i])
        );
    end

    result_serializer #(
        .NUM_LANES   (NUM_LANES),
        .FILTER_SIZE (FILTER_SIZE)
    ) ser_i (
        .clk        (clk),
        .rst        (rst),
        .results    (lane_results),
        .out_valid  (out_valid),
        .out_result (out_result),
        .done       (done)
    );

endmodule

`default_nettype wire

//--- tests/conv_row_engine_tb.sv
`timescale 1ns/100ps
`default_nettype none

module conv_row_engine_tb;
    import conv_pkg::*;

    localparam int FILTER_SIZE  = 4;
    localparam int NUM_LANES    = 4;
    localparam int STRIDE_W     = 3;
    localparam int TAP_W        = (FILTER_SIZE > 1) ? $clog2(FILTER_SIZE) : 1;
    localparam int JOB_TIMEOUT  = 2000;
    localparam int QUIET_CYCLES = 2 * FILTER_SIZE + NUM_LANES;

    logic                clk;
    logic                rst;
    logic                row_wr;
    row_idx_t            row_waddr;
    row_entry_t          row_wdata;
    logic                pix_wr;
    pix_addr_t           pix_waddr;
    pixel_t              pix_wdata;
    logic                wgt_wr;
    lane_idx_t           wgt_lane;
    logic [TAP_W-1:0]    wgt_tap;
    weight_t             wgt_data;
    logic                start;
    row_idx_t            num_rows;
    logic [STRIDE_W-1:0] stride;
    logic                busy;
    logic                out_valid;
    out_result_t         out_result;
    logic                done;

    // host-side copies of everything written into the engine.
    pixel_t      pix_mem [256];
    weight_t     wgt_mem [NUM_LANES][FILTER_SIZE];
    int          row_start [16];
    int          row_end [16];
    out_result_t exp_q [$];
    logic [31:0] lfsr_state = 32'hbb86_bd93;
    int          err_count = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    logic        timed_out = 1'b0;

    conv_row_engine #(
        .FILTER_SIZE (FILTER_SIZE),
        .NUM_LANES   (NUM_LANES),
        .STRIDE_W    (STRIDE_W)
    ) dut_i (
        .clk        (clk),
        .rst        (rst),
        .row_wr     (row_wr),
        .row_waddr  (row_waddr),
        .row_wdata  (row_wdata),
        .pix_wr     (pix_wr),
        .pix_waddr  (pix_waddr),
        .pix_wdata  (pix_wdata),
        .wgt_wr     (wgt_wr),
        .wgt_lane   (wgt_lane),
        .wgt_tap    (wgt_tap),
        .wgt_data   (wgt_data),
        .start      (start),
        .num_rows   (num_rows),
        .stride     (stride),
        .busy       (busy),
        .out_valid  (out_valid),
        .out_result (out_result),
        .done       (done)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // taps at bits 32, 22, 2 and 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    task automatic check_result(input string name, input out_result_t exp_r,
                                input out_result_t act_r);
        string exp_s;
        string act_s;
        if (act_r !== exp_r) begin
            exp_s = $sformatf("lane %0d sum %0d row %0d window %0d last %0b",
                              exp_r.lane, exp_r.sum, exp_r.tag.row, exp_r.tag.window,
                              exp_r.tag.last_of_job);
            act_s = $sformatf("lane %0d sum %0d row %0d window %0d last %0b",
                              act_r.lane, act_r.sum, act_r.tag.row, act_r.tag.window,
                              act_r.tag.last_of_job);
            $display("FAILED %s: expected %s actual %s", name, exp_s, act_s);
            err_count++;
        end
    endtask

    task automatic check_flag(input string name, input string what, input logic exp_v,
                              input logic act_v);
        if (act_v !== exp_v) begin
            $display("FAILED %s: %s expected %b actual %b", name, what, exp_v, act_v);
            err_count++;
        end
    endtask

    task automatic write_pixel(input int addr, input pixel_t val);
        @(posedge clk);
        pix_wr    <= 1'b1;
        pix_waddr <= pix_addr_t'(addr);
        pix_wdata <= val;
        pix_mem[addr] = val;
    endtask

    task automatic write_weight(input int lane, input int tap, input weight_t val);
        @(posedge clk);
        wgt_wr   <= 1'b1;
        wgt_lane <= lane_idx_t'(lane);
        wgt_tap  <= TAP_W'(tap);
        wgt_data <= val;
        wgt_mem[lane][tap] = val;
    endtask

    task automatic write_row(input int idx, input int s, input int e);
        @(posedge clk);
        row_wr    <= 1'b1;
        row_waddr <= row_idx_t'(idx);
        row_wdata <= {pix_addr_t'(s), pix_addr_t'(e)};
        row_start[idx] = s;
        row_end[idx]   = e;
    endtask

    task automatic end_writes();
        @(posedge clk);
        pix_wr <= 1'b0;
        wgt_wr <= 1'b0;
        row_wr <= 1'b0;
    endtask

    // expected results in output order: row, then window, then lane.
    task automatic build_expected(input int nrows, input int strd);
        out_result_t e;
        int nwin;
        int head;
        int acc;
        exp_q.delete();
        for (int r = 0; r < nrows; r++) begin
            nwin = 0;
            if (row_end[r] - row_start[r] >= FILTER_SIZE) begin
                nwin = (row_end[r] - row_start[r] - FILTER_SIZE) / strd + 1;
            end
            for (int w = 0; w < nwin; w++) begin
                head = row_start[r] + w * strd;
                for (int l = 0; l < NUM_LANES; l++) begin
                    acc = 0;
                    for (int k = 0; k < FILTER_SIZE; k++) begin
                        acc += int'(pix_mem[head + k]) * int'(wgt_mem[l][k]);
                    end
                    e.lane            = lane_idx_t'(l);
                    e.sum             = sum_t'(acc);
                    e.tag.row         = row_idx_t'(r);
                    e.tag.window      = win_idx_t'(w);
                    e.tag.last_of_job = 1'b0;
                    exp_q.push_back(e);
                end
            end
        end
        // every lane of the final window carries the end marker.
        for (int i = exp_q.size() - NUM_LANES; i < exp_q.size(); i++) begin
            if (i >= 0) begin
                e = exp_q[i];
                e.tag.last_of_job = 1'b1;
                exp_q[i] = e;
            end
        end
    endtask

    task automatic run_job(input string name, input int nrows, input int strd);
        out_result_t exp_r;
        int n_exp;
        int cycles;
        int done_cnt;
        if (timed_out) begin
            return;
        end
        build_expected(nrows, strd);
        n_exp = exp_q.size();
        @(posedge clk);
        start    <= 1'b1;
        num_rows <= row_idx_t'(nrows);
        stride   <= STRIDE_W'(strd);
        @(posedge clk);
        start <= 1'b0;
        @(negedge clk);
        check_flag(name, "busy after start", 1'b1, busy);
        cycles   = 0;
        done_cnt = 0;
        while (done_cnt == 0) begin
            @(negedge clk);
            cycles++;
            if (cycles > JOB_TIMEOUT) begin
                $display("%s: done never arrived within %0d cycles", name, JOB_TIMEOUT);
                err_count++;
                timed_out = 1'b1;
                return;
            end
            if (out_valid) begin
                if (exp_q.size() == 0) begin
                    $display("%s: a result arrived when none was expected", name);
                    err_count++;
                end else begin
                    exp_r = exp_q.pop_front();
                    check_result(name, exp_r, out_result);
                end
            end
            if (done) begin
                done_cnt++;
                check_flag(name, "out_valid with done", n_exp > 0, out_valid);
                check_flag(name, "busy with done", 1'b1, busy);
            end
        end
        if (exp_q.size() != 0) begin
            $display("%s: %0d results missing when done arrived", name, exp_q.size());
            err_count++;
        end
        // nothing may follow the end of the job.
        for (int i = 0; i < QUIET_CYCLES; i++) begin
            @(negedge clk);
            if (i == 0) begin
                check_flag(name, "busy after done", 1'b0, busy);
            end
            if (done) begin
                $display("%s: done pulsed more than once", name);
                err_count++;
            end
            if (out_valid) begin
                $display("%s: a result arrived after done", name);
                err_count++;
            end
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests_run++;
        if (err_count > errs_before) begin
            tests_failed++;
            $display("%s: failed with %0d errors", name, err_count - errs_before);
        end else begin
            $display("%s: passed", name);
        end
    endtask

    task automatic load_memories();
        for (int a = 0; a < 256; a++) begin
            write_pixel(a, pixel_t'(rand_bits(PIX_W)));
        end
        for (int l = 0; l < NUM_LANES; l++) begin
            for (int k = 0; k < FILTER_SIZE; k++) begin
                write_weight(l, k, weight_t'(rand_bits(WGT_W)));
            end
        end
        end_writes();
    endtask

    task automatic test_single_row();
        int errs;
        errs = err_count;
        write_row(0, 10, 20);
        end_writes();
        run_job("single_row_stride1", 1, 1);
        report_test("single_row_stride1", errs);
    endtask

    task automatic test_stride_unaligned();
        int errs;
        errs = err_count;
        // eleven pixels with stride 2 leave a partial window at 48.
        write_row(0, 40, 51);
        end_writes();
        run_job("stride2_unaligned", 1, 2);
        report_test("stride2_unaligned", errs);
    endtask

    task automatic test_multi_row();
        int errs;
        errs = err_count;
        write_row(0, 100, 109);
        write_row(1, 3, 5);
        write_row(2, 200, 212);
        write_row(3, 60, 62);
        end_writes();
        run_job("multi_row_short", 4, 2);
        report_test("multi_row_short", errs);
    endtask

    task automatic test_signed_extremes();
        int errs;
        errs = err_count;
        for (int k = 0; k < FILTER_SIZE; k++) begin
            write_weight(0, k, 8'sd127);
            write_weight(1, k, -8'sd128);
            write_weight(2, k, (k % 2 == 0) ? -8'sd128 : 8'sd127);
            write_weight(3, k, weight_t'(rand_bits(WGT_W)));
        end
        for (int a = 150; a < 158; a++) begin
            write_pixel(a, (a < 154) ? -8'sd128 : 8'sd127);
        end
        write_row(0, 150, 158);
        end_writes();
        run_job("signed_extremes", 1, 1);
        report_test("signed_extremes", errs);
    endtask

    task automatic test_job_control();
        int errs;
        errs = err_count;
        write_row(0, 20, 30);
        write_row(1, 0, 2);
        end_writes();
        run_job("job_control", 2, 3);
        // a job of short rows only must still end with done.
        write_row(0, 5, 7);
        write_row(1, 9, 9);
        end_writes();
        run_job("job_control_empty", 2, 1);
        report_test("job_control", errs);
    endtask

    initial begin
        rst       = 1'b1;
        row_wr    = 1'b0;
        row_waddr = '0;
        row_wdata = '0;
        pix_wr    = 1'b0;
        pix_waddr = '0;
        pix_wdata = '0;
        wgt_wr    = 1'b0;
        wgt_lane  = '0;
        wgt_tap   = '0;
        wgt_data  = '0;
        start     = 1'b0;
        num_rows  = '0;
        stride    = STRIDE_W'(1);
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        load_memories();
        test_single_row();
        test_stride_unaligned();
        test_multi_row();
        test_signed_extremes();
        test_job_control();
        $display("tests run %0d, tests failed %0d, checks failed %0d",
                 tests_run, tests_failed, err_count);
        if (err_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- conv_row_engine.f
hdl/conv_pkg.sv
hdl/ifmap_addr_gen.sv
hdl/ifmap_buffer.sv
hdl/mac_lane.sv
hdl/result_serializer.sv
hdl/conv_row_engine.sv
tests/conv_row_engine_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       := conv_row_engine_tb
FILELIST  := conv_row_engine.f
FLAGS     := --binary --timing --assert
OBJ_DIR   := obj_dir
PASS_MSG  := PASS: all tests

.PHONY: lint build sim clean

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -Fqx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
